// ==== build.f ====
+incdir+include
rtl/dbus_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_req_ctrl.sv
rtl/write_buffer.sv
rtl/data_mem.sv
rtl/dbus_top.sv
tests/dbus_assert.sv
tests/dbus_tb.sv

// ==== include/dbus_consts.svh ====
// Data bus width, memory depth, bufferable base address and memory wait macros
`ifndef DBUS_CONSTS_SVH
`define DBUS_CONSTS_SVH

////////////////////////////////////////
// Bus geometry
////////////////////////////////////////

// Byte address width of the data bus
`define DBUS_ADDR_W 12

// Word width, four byte lanes
`define DBUS_DATA_W 32

// Depth of the data memory in words
`define DBUS_MEM_WORDS 1024

////////////////////////////////////////
// Behaviour
////////////////////////////////////////

// Stores at or above this byte address may retire through the write buffer
`define DBUS_BUF_BASE 12'h800

// Busy cycles of the data memory after each accept
`define DBUS_MEM_WAIT 3

`endif

// ==== rtl/data_mem.sv ====
// Data memory: byte-enable word array, busy counter back-pressure, registered response
`timescale 1ns/1ps
`include "dbus_consts.svh"

module data_mem #(
  // Busy cycles after each accept, zero gives no stall
  parameter int WAIT_CYCLES = `DBUS_MEM_WAIT
) (
  input  logic                clk,
  input  logic                rst_n,
  // Request side
  input  logic                req_valid_i,
  input  dbus_pkg::dbus_req_t req_i,
  output logic                req_ready_o,
  // Response side
  output logic                rsp_valid_o,
  output dbus_pkg::dbus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`DBUS_MEM_WORDS);
  localparam int BE_W  = `DBUS_DATA_W / 8;
  // At least one bit, even for a zero wait
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  logic [`DBUS_DATA_W-1:0] mem [0:`DBUS_MEM_WORDS-1];
  logic [CNT_W-1:0]        busy_q;
  logic                    accept;
  logic [IDX_W-1:0]        idx;
  logic                    rsp_valid_q;
  dbus_pkg::dbus_rsp_t     rsp_q;

  ////////////////////////////////////////
  // Accept and back-pressure
  ////////////////////////////////////////

  assign req_ready_o = (busy_q == '0);
  assign accept      = req_valid_i && req_ready_o;
  // Word index, byte offset dropped
  assign idx         = req_i.addr[2 +: IDX_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (accept) begin
      // Blocks the next accept for WAIT_CYCLES cycles
      busy_q <= CNT_W'(WAIT_CYCLES);
    end else if (busy_q != '0) begin
      busy_q <= busy_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Word array
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept && req_i.we) begin
      // Merge only the enabled byte lanes
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Response, one cycle after accept
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      // Load sees the word before any write in this cycle, store answers zero
      rsp_q.rdata <= req_i.we ? '0 : mem[idx];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== rtl/dbus_pkg.sv ====
// Data bus request and response structs shared by controller, write buffer and memory
`include "dbus_consts.svh"

package dbus_pkg;

  ////////////////////////////////////////
  // Request channel
  ////////////////////////////////////////

  // One bus transaction, load or store
  typedef struct packed {
    // High for a store
    logic                         we;
    // Store may retire before the memory takes it
    logic                         bufferable;
    // Byte address, low two bits ignored by the memory
    logic [`DBUS_ADDR_W-1:0]      addr;
    // One enable per byte lane
    logic [`DBUS_DATA_W/8-1:0]    be;
    logic [`DBUS_DATA_W-1:0]      wdata;
  } dbus_req_t;

  ////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////

  // Read word for a load, zero for a store
  typedef struct packed {
    logic [`DBUS_DATA_W-1:0] rdata;
  } dbus_rsp_t;

endpackage

// ==== rtl/dbus_top.sv ====
// Data bus top level: request controller, write buffer and data memory
`timescale 1ns/1ps

module dbus_top (
  input  logic              clk,
  input  logic              rst_n,
  // Command side
  input  logic              cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t cmd_i,
  output logic              cmd_ready_o,
  // Result side
  output logic              res_valid_o,
  output lsu_pkg::lsu_res_t res_o,
  // Status
  output logic              wbuf_empty_o
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Controller to write buffer
  logic                ctrl_valid;
  dbus_pkg::dbus_req_t ctrl_req;
  logic                ctrl_ready;

  // Write buffer to memory
  logic                mem_valid;
  dbus_pkg::dbus_req_t mem_req;
  logic                mem_ready;

  // Memory straight back to controller
  logic                rsp_valid;
  dbus_pkg::dbus_rsp_t rsp;

  lsu_req_ctrl i_lsu_req_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .req_valid_o (ctrl_valid),
    .req_o       (ctrl_req),
    .req_ready_i (ctrl_ready),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp)
  );

  write_buffer i_write_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (ctrl_valid),
    .trans_i (ctrl_req),
    .ready_o (ctrl_ready),
    .valid_o (mem_valid),
    .trans_o (mem_req),
    .ready_i (mem_ready),
    .empty_o (wbuf_empty_o)
  );

  data_mem i_data_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (mem_valid),
    .req_i       (mem_req),
    .req_ready_o (mem_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

endmodule

// ==== rtl/lsu_pkg.sv ====
// Load/store command side types: opcode, command, result and FSM state enums
`include "dbus_consts.svh"

package lsu_pkg;

  // Command opcode
  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Command as it enters the controller
  typedef struct packed {
    lsu_op_e                      op;
    logic [`DBUS_ADDR_W-1:0]      addr;
    logic [`DBUS_DATA_W/8-1:0]    be;
    logic [`DBUS_DATA_W-1:0]      wdata;
  } lsu_cmd_t;

  // Result returned to the command side
  typedef struct packed {
    logic [`DBUS_DATA_W-1:0] rdata;
    // Set when the store retired through the write buffer
    logic                    buffered;
  } lsu_res_t;

  // Request controller states
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

  // Write buffer states
  typedef enum logic {
    WBUF_EMPTY,
    WBUF_FULL
  } wbuf_state_e;

endpackage

// ==== rtl/lsu_req_ctrl.sv ====
// Request controller: command accept, bufferable classification, bus request, response match
`timescale 1ns/1ps
`include "dbus_consts.svh"

module lsu_req_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  // Command side
  input  logic                cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t   cmd_i,
  output logic                cmd_ready_o,
  // Result side
  output logic                res_valid_o,
  output lsu_pkg::lsu_res_t   res_o,
  // Request side
  output logic                req_valid_o,
  output dbus_pkg::dbus_req_t req_o,
  input  logic                req_ready_i,
  // Response side
  input  logic                rsp_valid_i,
  input  dbus_pkg::dbus_rsp_t rsp_i
);

  lsu_pkg::lsu_state_e state_q, state_d;
  dbus_pkg::dbus_req_t req_q;
  lsu_pkg::lsu_res_t   res_q;
  logic                res_valid_q;
  // Buffered stores whose memory responses are still due
  logic [2:0]          discard_q;

  logic cmd_fire;
  logic req_fire;
  logic buf_fire;
  logic rsp_drop;
  logic rsp_take;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign cmd_fire = cmd_valid_i && cmd_ready_o;
  assign req_fire = req_valid_o && req_ready_i;
  // Store retired early, its response arrives later
  assign buf_fire = req_fire && req_q.bufferable;
  // Responses are in order, so the oldest due ones belong to buffered stores
  assign rsp_drop = rsp_valid_i && (discard_q != 3'd0);
  assign rsp_take = rsp_valid_i && (discard_q == 3'd0) && (state_q == lsu_pkg::LSU_WAIT);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::LSU_IDLE: begin
        if (cmd_fire) begin
          state_d = lsu_pkg::LSU_REQ;
        end
      end
      lsu_pkg::LSU_REQ: begin
        if (req_fire) begin
          // Buffered store is done, everything else waits for memory
          state_d = req_q.bufferable ? lsu_pkg::LSU_IDLE : lsu_pkg::LSU_WAIT;
        end
      end
      lsu_pkg::LSU_WAIT: begin
        if (rsp_take) begin
          state_d = lsu_pkg::LSU_IDLE;
        end
      end
      default: state_d = lsu_pkg::LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= lsu_pkg::LSU_IDLE;
      res_valid_q <= 1'b0;
      discard_q   <= 3'd0;
    end else begin
      state_q     <= state_d;
      res_valid_q <= buf_fire || rsp_take;
      // Push and pop in the same cycle leave the count unchanged
      case ({buf_fire, rsp_drop})
        2'b10:   discard_q <= discard_q + 3'd1;
        2'b01:   discard_q <= discard_q - 3'd1;
        default: discard_q <= discard_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // Request and result registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      req_q.we         <= (cmd_i.op == lsu_pkg::LSU_STORE);
      // Only place where the address is classified
      req_q.bufferable <= (cmd_i.op == lsu_pkg::LSU_STORE) && (cmd_i.addr >= `DBUS_BUF_BASE);
      req_q.addr       <= cmd_i.addr;
      req_q.be         <= cmd_i.be;
      req_q.wdata      <= cmd_i.wdata;
    end
    if (buf_fire) begin
      res_q.rdata    <= '0;
      res_q.buffered <= 1'b1;
    end else if (rsp_take) begin
      res_q.rdata    <= rsp_i.rdata;
      res_q.buffered <= 1'b0;
    end
  end

  // Held off while the previous result is still on the port
  assign cmd_ready_o = (state_q == lsu_pkg::LSU_IDLE) && !res_valid_q;
  assign req_valid_o = (state_q == lsu_pkg::LSU_REQ);
  assign req_o       = req_q;
  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

// ==== rtl/write_buffer.sv ====
// Single-entry write buffer for bufferable stores between controller and memory
`timescale 1ns/1ps

module write_buffer (
  input  logic                clk,
  input  logic                rst_n,
  // Upstream, from the controller
  input  logic                valid_i,
  input  dbus_pkg::dbus_req_t trans_i,
  output logic                ready_o,
  // Downstream, to the memory
  output logic                valid_o,
  output dbus_pkg::dbus_req_t trans_o,
  input  logic                ready_i,
  // Status
  output logic                empty_o
);

  lsu_pkg::wbuf_state_e state_q, state_d;
  dbus_pkg::dbus_req_t  trans_q;
  logic                 push;
  logic                 bufferable;

  // Classification comes from the request, never from the address
  assign bufferable = trans_i.bufferable;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    push    = 1'b0;
    case (state_q)
      lsu_pkg::WBUF_EMPTY: begin
        // Downstream stalled, park the store here
        if (valid_i && bufferable && !ready_i) begin
          state_d = lsu_pkg::WBUF_FULL;
          push    = 1'b1;
        end
      end
      lsu_pkg::WBUF_FULL: begin
        if (ready_i) begin
          // Stored entry drains, a new bufferable store may take its place
          if (valid_i && bufferable) begin
            push = 1'b1;
          end else begin
            state_d = lsu_pkg::WBUF_EMPTY;
          end
        end
      end
      default: state_d = lsu_pkg::WBUF_EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= lsu_pkg::WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      trans_q <= trans_i;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Full: only a bufferable store, and only while the entry drains
  // Empty: bufferable always, anything else if downstream is ready
  assign ready_o = (state_q == lsu_pkg::WBUF_FULL) ? (bufferable && ready_i)
                                                   : (bufferable || ready_i);

  // Pass-through when empty, stored entry when full
  assign valid_o = (state_q == lsu_pkg::WBUF_FULL) || valid_i;
  assign trans_o = (state_q == lsu_pkg::WBUF_FULL) ? trans_q : trans_i;

  assign empty_o = (state_q == lsu_pkg::WBUF_EMPTY);

endmodule

// ==== tests/dbus_assert.sv ====
// Bound assertions on the data bus top level: request stability, result timing, buffer contents
`timescale 1ns/1ps

module dbus_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                cmd_valid_i,
  input lsu_pkg::lsu_cmd_t   cmd_i,
  input logic                cmd_ready_i,
  input logic                res_valid_i,
  input logic                ctrl_valid_i,
  input dbus_pkg::dbus_req_t ctrl_req_i,
  input logic                ctrl_ready_i,
  input logic                mem_valid_i,
  input dbus_pkg::dbus_req_t mem_req_i,
  input logic                mem_ready_i,
  input logic                wbuf_empty_i
);

  // Number of assertion failures so far
  int fail_count = 0;

  ////////////////////////////////////////
  // Stalled requests hold
  ////////////////////////////////////////

  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
    else begin
      fail_count++;
      $error("command changed or dropped before transfer");
    end

  ctrl_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid_i && !ctrl_ready_i |=> ctrl_valid_i && $stable(ctrl_req_i))
    else begin
      fail_count++;
      $error("controller request changed or dropped while stalled");
    end

  mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
    else begin
      fail_count++;
      $error("memory request changed or dropped while stalled");
    end

  ////////////////////////////////////////
  // Result timing and ordering
  ////////////////////////////////////////

  // Next command only after the result pulse
  ready_res_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_ready_i && res_valid_i))
    else begin
      fail_count++;
      $error("cmd_ready and res_valid high together");
    end

  // Full buffer drives its entry downstream, which must be bufferable
  wbuf_content: assert property (@(posedge clk) disable iff (!rst_n)
    !wbuf_empty_i |-> mem_req_i.bufferable)
    else begin
      fail_count++;
      $error("write buffer holds a non-bufferable request");
    end

endmodule

bind dbus_top dbus_assert i_dbus_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .cmd_valid_i  (cmd_valid_i),
  .cmd_i        (cmd_i),
  .cmd_ready_i  (cmd_ready_o),
  .res_valid_i  (res_valid_o),
  .ctrl_valid_i (ctrl_valid),
  .ctrl_req_i   (ctrl_req),
  .ctrl_ready_i (ctrl_ready),
  .mem_valid_i  (mem_valid),
  .mem_req_i    (mem_req),
  .mem_ready_i  (mem_ready),
  .wbuf_empty_i (wbuf_empty_o)
);

// ==== tests/dbus_tb.sv ====
// Testbench for the data bus path: command table, reference memory model, checks and summary
`timescale 1ns/1ps
`include "dbus_consts.svh"

module dbus_tb;

  localparam int TIMEOUT_CYCLES = 40;
  localparam int IDLE_CYCLES    = 30;

  // One table row, expected retire path included
  typedef struct packed {
    lsu_pkg::lsu_op_e          op;
    logic [`DBUS_ADDR_W-1:0]   addr;
    logic [`DBUS_DATA_W/8-1:0] be;
    logic [`DBUS_DATA_W-1:0]   wdata;
    logic                      exp_buffered;
  } row_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              cmd_valid;
  lsu_pkg::lsu_cmd_t cmd;
  logic              cmd_ready;
  logic              res_valid;
  lsu_pkg::lsu_res_t res;
  logic              wbuf_empty;

  row_t                    cmd_table [$];
  // Reference memory, only read after a full-word store
  logic [`DBUS_DATA_W-1:0] ref_mem [0:`DBUS_MEM_WORDS-1];
  int                      check_count;
  int                      error_count;
  int                      timeout_count;

  // 20 ns clock
  always #10 clk = ~clk;

  dbus_top i_dbus_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_ready_o  (cmd_ready),
    .res_valid_o  (res_valid),
    .res_o        (res),
    .wbuf_empty_o (wbuf_empty)
  );

  ////////////////////////////////////////
  // Model and table helpers
  ////////////////////////////////////////

  // Enabled byte lanes take the new data, the rest keep the old word
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic add_row(input lsu_pkg::lsu_op_e op, input logic [11:0] addr,
                         input logic [3:0] be, input logic exp_buffered);
    row_t r;
    r.op           = op;
    r.addr         = addr;
    r.be           = be;
    r.wdata        = (op == lsu_pkg::LSU_STORE) ? $urandom : '0;
    r.exp_buffered = exp_buffered;
    cmd_table.push_back(r);
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Handshake waits, sampled on the falling edge
  ////////////////////////////////////////

  task automatic wait_ready(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (cmd_ready) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
  endtask

  task automatic wait_result(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (res_valid) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
  endtask

  // Issue one row, wait for its result and check it against the model
  task automatic run_row(input int idx);
    row_t              r;
    bit                seen;
    int                errors_before;
    lsu_pkg::lsu_res_t got;
    logic [31:0]       exp_rdata;
    r             = cmd_table[idx];
    errors_before = error_count;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd.op    <= r.op;
    cmd.addr  <= r.addr;
    cmd.be    <= r.be;
    cmd.wdata <= r.wdata;
    wait_ready(seen);
    if (!seen) begin
      timeout_count++;
      $display("Row %0d: the command was never accepted, cmd_ready stayed low", idx);
      @(posedge clk);
      cmd_valid <= 1'b0;
      return;
    end
    // Transfer on this edge
    @(posedge clk);
    cmd_valid <= 1'b0;
    wait_result(seen);
    if (!seen) begin
      timeout_count++;
      $display("Row %0d: no result came back for the command", idx);
      return;
    end
    got = res;
    if (r.op == lsu_pkg::LSU_STORE) begin
      ref_mem[r.addr[`DBUS_ADDR_W-1:2]] = merge_word(ref_mem[r.addr[`DBUS_ADDR_W-1:2]],
                                                     r.wdata, r.be);
      exp_rdata = '0;
    end else begin
      exp_rdata = ref_mem[r.addr[`DBUS_ADDR_W-1:2]];
    end
    compare("result rdata", got.rdata, exp_rdata);
    compare("result buffered", 32'(got.buffered), 32'(r.exp_buffered));
    $display("Row %0d %s addr %h be %b: %s", idx, r.op.name(), r.addr, r.be,
             (error_count == errors_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int idle;
    void'($urandom(32'h048a_b481));
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd           = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    // Columns: op, byte address, byte enables, expected buffered flag
    // Plain store then load, below the base
    add_row(lsu_pkg::LSU_STORE, 12'h010, 4'hf, 1'b0);
    add_row(lsu_pkg::LSU_LOAD,  12'h010, 4'hf, 1'b0);
    // Back-to-back buffered stores, then read both back
    add_row(lsu_pkg::LSU_STORE, 12'h900, 4'hf, 1'b1);
    add_row(lsu_pkg::LSU_STORE, 12'h904, 4'hf, 1'b1);
    add_row(lsu_pkg::LSU_LOAD,  12'h900, 4'hf, 1'b0);
    add_row(lsu_pkg::LSU_LOAD,  12'h904, 4'hf, 1'b0);
    // Partial merges, plain and buffered
    add_row(lsu_pkg::LSU_STORE, 12'h020, 4'hf, 1'b0);
    add_row(lsu_pkg::LSU_STORE, 12'h020, 4'b0101, 1'b0);
    add_row(lsu_pkg::LSU_LOAD,  12'h020, 4'hf, 1'b0);
    add_row(lsu_pkg::LSU_STORE, 12'ha00, 4'hf, 1'b1);
    add_row(lsu_pkg::LSU_STORE, 12'ha00, 4'b1000, 1'b1);
    add_row(lsu_pkg::LSU_STORE, 12'ha00, 4'b0010, 1'b1);
    add_row(lsu_pkg::LSU_LOAD,  12'ha00, 4'hf, 1'b0);
    // Last word below the base is never buffered
    add_row(lsu_pkg::LSU_STORE, 12'h7fc, 4'hf, 1'b0);
    add_row(lsu_pkg::LSU_LOAD,  12'h7fc, 4'hf, 1'b0);
    // Load right behind a buffered store to the base word
    add_row(lsu_pkg::LSU_STORE, 12'h800, 4'hf, 1'b1);
    add_row(lsu_pkg::LSU_LOAD,  12'h800, 4'hf, 1'b0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare("cmd_ready after reset", 32'(cmd_ready), 32'd1);
    compare("wbuf_empty after reset", 32'(wbuf_empty), 32'd1);
    compare("res_valid after reset", 32'(res_valid), 32'd0);
    for (int i = 0; i < cmd_table.size(); i++) begin
      run_row(i);
    end
    // Long idle, no stray result may show up
    idle = 0;
    while (idle < IDLE_CYCLES) begin
      @(negedge clk);
      compare("res_valid while idle", 32'(res_valid), 32'd0);
      idle++;
    end
    compare("wbuf_empty after idle", 32'(wbuf_empty), 32'd1);
    compare("cmd_ready after idle", 32'(cmd_ready), 32'd1);
    compare("assertion failures", 32'(i_dbus_top.i_dbus_assert.fail_count), 32'd0);
    $display("Rows %0d, checks %0d, errors %0d, timeouts %0d",
             cmd_table.size(), check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
